//--- bridge_pkg.sv
/*
 * bridge bus register map and core hold length
 * bridge request struct for one bus cycle
 * dip bank and configuration register structs
 */

package bridge_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // register map

    // core reset command, write only strobe, reads back core run
    localparam logic [31:0] bridge_addr_reset    = 32'hF000_0000;
    // dip switch bank, a write also restarts the core
    localparam logic [31:0] bridge_addr_dip      = 32'hF100_0000;
    // core mode selection word
    localparam logic [31:0] bridge_addr_mode     = 32'hF200_0000;
    // scanline word, low nibble is the level
    localparam logic [31:0] bridge_addr_scanline = 32'hF300_0000;

    // default core hold after a reset command, in clk_74a cycles
    localparam logic [31:0] reset_hold_cycles = 32'd8000;

    ////////////////////////////////////////////////////////////////////////////
    // bus and register types

    // one bridge cycle, rd and wr are single cycle strobes
    typedef struct packed {
        logic [31:0] addr;
        logic        rd;
        logic        wr;
        logic [31:0] wr_data;
    } bridge_req_t;

    // dip word as written by the host, dsw0 in the low byte
    typedef struct packed {
        logic [7:0] spare;
        logic [7:0] dsw2;
        logic [7:0] dsw1;
        logic [7:0] dsw0;
    } dip_bank_t;

    // full configuration seen by the core
    typedef struct packed {
        dip_bank_t   dip;
        logic [31:0] mode;
        logic [31:0] scanline;
        logic [3:0]  scanline_level;
    } cfg_regs_t;

endpackage

//--- control_pkg.sv
/*
 * controller key bitmap positions
 * player count and key word array
 * active-low control panel word
 */

package control_pkg;

    // bit positions in a controller key word
    localparam int key_up     = 0;
    localparam int key_down   = 1;
    localparam int key_left   = 2;
    localparam int key_right  = 3;
    localparam int key_face_b = 5;
    localparam int key_face_y = 7;
    localparam int key_select = 14;
    localparam int key_start  = 15;

    // players merged into the panel
    localparam int num_players = 2;

    // key words, index 0 is player one
    typedef logic [num_players-1:0][31:0] pad_keys_t;

    ////////////////////////////////////////////////////////////////////////////
    // control panel, low means pressed

    typedef struct packed {
        logic coin;
        logic start2;
        logic start1;
        logic shoot2;
        logic shoot;
        logic up;
        logic down;
        logic left;
        logic right;
    } ctrl_panel_t;

endpackage

//--- bridge_decode.sv
/*
 * bridge write decode
 * holds dip, mode and scanline registers
 * issues the core reset command strobe
 */

`timescale 1ns/100ps

module bridge_decode
    import bridge_pkg::*;
(
    input  logic        clk_74a,
    input  logic        temp_reset,
    input  bridge_req_t bridge_req,
    output cfg_regs_t   cfg,
    output logic        core_reset_cmd
);

    // address matches, only meaningful with a write strobe
    logic hit_reset;
    logic hit_dip;
    logic hit_mode;
    logic hit_scanline;

    assign hit_reset    = bridge_req.wr && (bridge_req.addr == bridge_addr_reset);
    assign hit_dip      = bridge_req.wr && (bridge_req.addr == bridge_addr_dip);
    assign hit_mode     = bridge_req.wr && (bridge_req.addr == bridge_addr_mode);
    assign hit_scanline = bridge_req.wr && (bridge_req.addr == bridge_addr_scanline);

    ////////////////////////////////////////////////////////////////////////////
    // configuration registers

    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            cfg <= '0;
        end else begin
            if (hit_dip) begin
                cfg.dip <= dip_bank_t'(bridge_req.wr_data);
            end
            if (hit_mode) begin
                cfg.mode <= bridge_req.wr_data;
            end
            // level nibble kept alongside the full word
            if (hit_scanline) begin
                cfg.scanline       <= bridge_req.wr_data;
                cfg.scanline_level <= bridge_req.wr_data[3:0];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // reset command

    // one cycle strobe after a reset or dip write
    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            core_reset_cmd <= 1'b0;
        end else begin
            core_reset_cmd <= hit_reset || hit_dip;
        end
    end

endmodule

//--- core_reset_timer.sv
/*
 * core hold timer
 * down-counter reloaded by reset commands and temp_reset
 */

`timescale 1ns/100ps

module core_reset_timer
    import bridge_pkg::*;
#(
    parameter logic [31:0] hold_cycles = reset_hold_cycles
) (
    input  logic clk_74a,
    input  logic temp_reset,
    input  logic core_reset_cmd,
    output logic core_run
);

    // remaining hold cycles
    logic [31:0] hold_count;

    // reload on either source, a command mid-hold restarts the count
    // core runs on the first edge that sees zero
    // so run stays low for hold_cycles+1 cycles
    always_ff @(posedge clk_74a) begin
        if (temp_reset || core_reset_cmd) begin
            hold_count <= hold_cycles;
            core_run   <= 1'b0;
        end else if (hold_count == 32'd0) begin
            core_run <= 1'b1;
        end else begin
            hold_count <= hold_count - 32'd1;
            core_run   <= 1'b0;
        end
    end

endmodule

//--- control_panel_mapper.sv
/*
 * controller to control panel mapping
 * merges both players and registers the active-low word
 */

`timescale 1ns/100ps

module control_panel_mapper
    import control_pkg::*;
(
    input  logic        clk_74a,
    input  logic        temp_reset,
    input  pad_keys_t   pad_keys,
    output ctrl_panel_t panel
);

    // merged panel, high means pressed
    ctrl_panel_t pressed;

    ////////////////////////////////////////////////////////////////////////////
    // player merge

    always_comb begin
        pressed = '0;
        // shared controls, any player
        for (int p = 0; p < num_players; p++) begin
            pressed.up     |= pad_keys[p][key_up];
            pressed.down   |= pad_keys[p][key_down];
            pressed.left   |= pad_keys[p][key_left];
            pressed.right  |= pad_keys[p][key_right];
            pressed.shoot  |= pad_keys[p][key_face_b];
            pressed.shoot2 |= pad_keys[p][key_face_y];
            pressed.coin   |= pad_keys[p][key_select];
        end
        // start buttons stay per player
        pressed.start1 = pad_keys[0][key_start];
        pressed.start2 = pad_keys[1][key_start];
    end

    // inverted and registered, idle panel is all ones
    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            panel <= '1;
        end else begin
            panel <= ctrl_panel_t'(~pressed);
        end
    end

endmodule

//--- bridge_readback.sv
/*
 * bridge register read-back
 * one cycle read buffer and address-selected read data
 */

`timescale 1ns/100ps

module bridge_readback
    import bridge_pkg::*;
(
    input  logic        clk_74a,
    input  logic        temp_reset,
    input  bridge_req_t bridge_req,
    input  cfg_regs_t   cfg,
    input  logic        core_run,
    output logic [31:0] bridge_rd_data
);

    logic [31:0] rd_buffer;
    // present address is one of the four registers
    logic        addr_known;

    assign addr_known = (bridge_req.addr == bridge_addr_reset)
                     || (bridge_req.addr == bridge_addr_dip)
                     || (bridge_req.addr == bridge_addr_mode)
                     || (bridge_req.addr == bridge_addr_scanline);

    ////////////////////////////////////////////////////////////////////////////
    // read buffer, loaded on the read strobe

    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            rd_buffer <= '0;
        end else if (bridge_req.rd) begin
            case (bridge_req.addr)
                // reset register reports core run in bit 0
                bridge_addr_reset:    rd_buffer <= {31'd0, core_run};
                bridge_addr_dip:      rd_buffer <= cfg.dip;
                bridge_addr_mode:     rd_buffer <= cfg.mode;
                bridge_addr_scanline: rd_buffer <= cfg.scanline;
                default:              rd_buffer <= '0;
            endcase
        end
    end

    // reader holds the address one more cycle
    // unlisted addresses read zero
    assign bridge_rd_data = addr_known ? rd_buffer : 32'd0;

endmodule

//--- core_control_top.sv
/*
 * core control path top level
 * bridge decode, reset timer, panel mapper and read-back
 */

`timescale 1ns/100ps

module core_control_top
    import bridge_pkg::*;
    import control_pkg::*;
#(
    parameter logic [31:0] hold_cycles = reset_hold_cycles
) (
    input  logic        clk_74a,
    input  logic        temp_reset,
    input  bridge_req_t bridge_req,
    input  pad_keys_t   pad_keys,
    output logic [31:0] bridge_rd_data,
    output cfg_regs_t   cfg,
    output logic        core_run,
    output ctrl_panel_t panel
);

    // decode to timer strobe
    logic core_reset_cmd;

    ////////////////////////////////////////////////////////////////////////////
    // bridge writes and core hold

    bridge_decode bridge_decode_inst (
        .clk_74a        (clk_74a),
        .temp_reset     (temp_reset),
        .bridge_req     (bridge_req),
        .cfg            (cfg),
        .core_reset_cmd (core_reset_cmd)
    );

    core_reset_timer #(
        .hold_cycles (hold_cycles)
    ) core_reset_timer_inst (
        .clk_74a        (clk_74a),
        .temp_reset     (temp_reset),
        .core_reset_cmd (core_reset_cmd),
        .core_run       (core_run)
    );

    ////////////////////////////////////////////////////////////////////////////
    // controls and read-back

    control_panel_mapper control_panel_mapper_inst (
        .clk_74a    (clk_74a),
        .temp_reset (temp_reset),
        .pad_keys   (pad_keys),
        .panel      (panel)
    );

    bridge_readback bridge_readback_inst (
        .clk_74a        (clk_74a),
        .temp_reset     (temp_reset),
        .bridge_req     (bridge_req),
        .cfg            (cfg),
        .core_run       (core_run),
        .bridge_rd_data (bridge_rd_data)
    );

endmodule

//--- tb_checks.svh
/*
 * compare tasks for read data, configuration fields, panel and core run
 * mismatch and failure counters
 */

`ifndef tb_checks_svh
`define tb_checks_svh

// wrong values and other failures counted apart
int mismatch_count = 0;
int failure_count  = 0;

// timeouts, file trouble and similar
task automatic report_failure(input string what);
    failure_count++;
    $display("error at %0t ns: %s", $time, what);
endtask

// read data and configuration fields, narrow fields zero extended
task automatic compare_word(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
        mismatch_count++;
        $display("mismatch %s: got 0x%08h expected 0x%08h", name, actual, expected);
    end
endtask

// panel word, low means pressed
task automatic compare_panel(input ctrl_panel_t actual, input ctrl_panel_t expected);
    if (actual !== expected) begin
        mismatch_count++;
        $display("mismatch panel: got 0x%03h expected 0x%03h", actual, expected);
    end
endtask

task automatic compare_run(input logic actual, input logic expected);
    if (actual !== expected) begin
        mismatch_count++;
        $display("mismatch core_run: got 0x%0h expected 0x%0h", actual, expected);
    end
endtask

`endif

//--- tb_core_control.sv
/*
 * testbench for the core control path
 * clock, reset, vectors from core_control_input.txt, random pad test, watchdog
 */

`timescale 1ns/100ps

module tb_core_control
    import bridge_pkg::*;
    import control_pkg::*;
;
    // short hold keeps the run brief
    localparam logic [31:0] tb_hold = 32'd20;

    logic          clk_74a = 1'b0;
    logic          temp_reset;
    bridge_req_t   bridge_req;
    pad_keys_t     pad_keys;
    logic [31:0]   bridge_rd_data;
    cfg_regs_t     cfg;
    logic          core_run;
    ctrl_panel_t   panel;

    // operations from the data file
    logic [7:0]    op_q[$];
    logic [31:0]   arg_a_q[$];
    logic [31:0]   arg_b_q[$];
    logic [31:0]   arg_c_q[$];
    logic          vectors_loaded = 1'b0;
    logic [31:0]   rng_state = 32'h617b;

    `include "tb_checks.svh"

    always #20 clk_74a = ~clk_74a;

    core_control_top #(
        .hold_cycles (tb_hold)
    ) core_control_top_inst (
        .clk_74a        (clk_74a),
        .temp_reset     (temp_reset),
        .bridge_req     (bridge_req),
        .pad_keys       (pad_keys),
        .bridge_rd_data (bridge_rd_data),
        .cfg            (cfg),
        .core_run       (core_run),
        .panel          (panel)
    );

    ////////////////////////////////////////////////////////////////////////////
    // reference model and random keys

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // both players merged, start buttons per player, then inverted
    function automatic ctrl_panel_t expected_panel(input logic [31:0] k0, input logic [31:0] k1);
        ctrl_panel_t p;
        p.up     = k0[key_up] | k1[key_up];
        p.down   = k0[key_down] | k1[key_down];
        p.left   = k0[key_left] | k1[key_left];
        p.right  = k0[key_right] | k1[key_right];
        p.shoot  = k0[key_face_b] | k1[key_face_b];
        p.shoot2 = k0[key_face_y] | k1[key_face_y];
        p.coin   = k0[key_select] | k1[key_select];
        p.start1 = k0[key_start];
        p.start2 = k1[key_start];
        return ctrl_panel_t'(~p);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // bus and pad drivers

    // write strobe sampled at the second edge
    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk_74a);
        bridge_req.addr    <= addr;
        bridge_req.wr_data <= data;
        bridge_req.rd      <= 1'b0;
        bridge_req.wr      <= 1'b1;
        @(posedge clk_74a);
        bridge_req.wr <= 1'b0;
    endtask

    // address held after the strobe, data sampled mid cycle
    task automatic read_check(input logic [31:0] addr, input logic [31:0] expected);
        @(posedge clk_74a);
        bridge_req.addr <= addr;
        bridge_req.wr   <= 1'b0;
        bridge_req.rd   <= 1'b1;
        @(posedge clk_74a);
        bridge_req.rd <= 1'b0;
        @(negedge clk_74a);
        compare_word($sformatf("bridge_rd_data at 0x%08h", addr), bridge_rd_data, expected);
    endtask

    task automatic apply_pad(input logic [31:0] k0, input logic [31:0] k1,
                             input ctrl_panel_t expected);
        @(posedge clk_74a);
        pad_keys[0] <= k0;
        pad_keys[1] <= k1;
        @(posedge clk_74a);
        @(negedge clk_74a);
        compare_panel(panel, expected);
    endtask

    // field slices of the register just written
    task automatic check_written(input logic [31:0] addr, input logic [31:0] data);
        case (addr)
            bridge_addr_dip: begin
                compare_word("cfg.dip", cfg.dip, data);
                compare_word("cfg.dip.dsw0", {24'd0, cfg.dip.dsw0}, {24'd0, data[7:0]});
                compare_word("cfg.dip.dsw1", {24'd0, cfg.dip.dsw1}, {24'd0, data[15:8]});
                compare_word("cfg.dip.dsw2", {24'd0, cfg.dip.dsw2}, {24'd0, data[23:16]});
            end
            bridge_addr_mode: compare_word("cfg.mode", cfg.mode, data);
            bridge_addr_scanline: begin
                compare_word("cfg.scanline", cfg.scanline, data);
                compare_word("cfg.scanline_level", {28'd0, cfg.scanline_level},
                             {28'd0, data[3:0]});
            end
            default: ;
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // core hold checks

    // write, then count the cycles with core_run low
    task automatic check_hold(input logic [31:0] addr, input logic [31:0] data,
                              input logic drop);
        int low_cycles;
        low_cycles = 0;
        write_reg(addr, data);
        @(negedge clk_74a);
        check_written(addr, data);
        compare_run(core_run, 1'b1);
        if (drop) begin
            @(negedge clk_74a);
            while (!core_run && low_cycles < tb_hold + 10) begin
                low_cycles++;
                @(negedge clk_74a);
            end
            compare_word("core_run low cycles", low_cycles, tb_hold + 1);
        end else begin
            repeat (tb_hold + 2) begin
                @(negedge clk_74a);
                if (!core_run) low_cycles++;
            end
            compare_word("core_run low cycles", low_cycles, 32'd0);
        end
    endtask

    task automatic wait_core_run();
        int n;
        n = 0;
        while (!core_run && n < tb_hold + 10) begin
            n++;
            @(negedge clk_74a);
        end
        if (!core_run) report_failure("core_run did not rise after the reset hold");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // data file

    // columns: operation letter, then three hex fields
    task automatic load_vectors();
        int fd;
        int code;
        logic [7:0] op;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        fd = $fopen("core_control_input.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open core_control_input.txt");
        end else begin
            code = 4;
            while (code == 4) begin
                code = $fscanf(fd, " %c %h %h %h", op, f1, f2, f3);
                if (code == 4) begin
                    op_q.push_back(op);
                    arg_a_q.push_back(f1);
                    arg_b_q.push_back(f2);
                    arg_c_q.push_back(f3);
                end else if (code > 0) begin
                    report_failure($sformatf("malformed line after operation %0d", op_q.size()));
                end
            end
            $fclose(fd);
            if (op_q.size() == 0) report_failure("no operations in core_control_input.txt");
        end
        vectors_loaded = 1'b1;
    endtask

    task automatic run_vectors();
        for (int i = 0; i < op_q.size(); i++) begin
            case (op_q[i])
                "w": begin
                    write_reg(arg_a_q[i], arg_b_q[i]);
                    @(negedge clk_74a);
                    check_written(arg_a_q[i], arg_b_q[i]);
                end
                "r": read_check(arg_a_q[i], arg_b_q[i]);
                "p": apply_pad(arg_a_q[i], arg_b_q[i], ctrl_panel_t'(arg_c_q[i][8:0]));
                "h": check_hold(arg_a_q[i], arg_b_q[i], arg_c_q[i][0]);
                default: report_failure($sformatf("unknown operation in entry %0d", i + 1));
            endcase
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence and watchdog

    initial begin
        logic [31:0] k0;
        logic [31:0] k1;
        temp_reset = 1'b1;
        bridge_req = '0;
        pad_keys   = '0;
        load_vectors();
        repeat (8) @(posedge clk_74a);
        temp_reset <= 1'b0;
        // idle state straight after reset, core still held
        @(negedge clk_74a);
        compare_panel(panel, '1);
        compare_word("cfg.dip", cfg.dip, 32'd0);
        compare_word("cfg.mode", cfg.mode, 32'd0);
        compare_word("cfg.scanline", cfg.scanline, 32'd0);
        compare_word("cfg.scanline_level", {28'd0, cfg.scanline_level}, 32'd0);
        compare_run(core_run, 1'b0);
        read_check(bridge_addr_reset, 32'd0);
        wait_core_run();
        // buffer now holds core run, hidden once the address leaves the map
        read_check(bridge_addr_reset, 32'd1);
        @(posedge clk_74a);
        bridge_req.addr <= 32'hF800_0000;
        @(negedge clk_74a);
        compare_word("bridge_rd_data at 0xf8000000 without strobe", bridge_rd_data, 32'd0);
        run_vectors();
        // random key pairs
        repeat (200) begin
            rng_state = xorshift(rng_state);
            k0 = rng_state;
            rng_state = xorshift(rng_state);
            k1 = rng_state;
            apply_pad(k0, k1, expected_panel(k0, k1));
        end
        finish_run();
    end

    // budget grows with the number of operations
    initial begin
        longint watchdog_cycles;
        wait (vectors_loaded);
        watchdog_cycles = longint'(op_q.size()) * (tb_hold + 10) + 2000;
        #(watchdog_cycles * 40);
        report_failure($sformatf("watchdog expired after %0d cycles", watchdog_cycles));
        finish_run();
    end

endmodule

//--- core_control_input.txt
r F0000000 00000001 0
r F1000000 00000000 0
r F2000000 00000000 0
r F3000000 00000000 0
w F2000000 00000003 0
r F2000000 00000003 0
w F3000000 0000A5C7 0
r F3000000 0000A5C7 0
h F1000000 00C3A512 1
r F1000000 00C3A512 0
r F0000000 00000001 0
h F0000000 00000000 1
h F2000000 00000011 0
h F3000000 0000000F 0
r F2000000 00000011 0
r F8000000 00000000 0
r F8000004 00000000 0
r 00000000 00000000 0
p 00000000 00000000 1FF
p 00000001 00000000 1F7
p 00000000 00008000 17F
p 00004020 00000080 0CF
p 0000800E 0000C001 030

//--- src.f
+incdir+.
bridge_pkg.sv
control_pkg.sv
bridge_decode.sv
core_reset_timer.sv
control_panel_mapper.sv
bridge_readback.sv
core_control_top.sv
tb_core_control.sv
